//--- tb.f
rtl/nes_glue_pkg.sv
rtl/reset_sequencer.sv
rtl/pad_mapper.sv
rtl/joypad_shifter.sv
rtl/rv_mem_bridge.sv
rtl/nes_glue_top.sv
verif/tb_nes_glue_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_nes_glue_top
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o sim
	./$(OBJDIR)/sim | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- verif/tb_nes_glue_top.sv
// Directed testbench for the console glue core
// Clock, half-word memory responder with random ack delay, check task
// Tests for reset release, loading, pad readout and the memory bridge
`timescale 1ns/1ns

module tb_nes_glue_top;

  logic                       clk;
  logic                       resetn;
  logic                       reset_btn;
  nes_glue_pkg::pad_report_t  pad1;
  nes_glue_pkg::pad_report_t  pad2;
  nes_glue_pkg::nes_buttons_t extra1;
  nes_glue_pkg::nes_buttons_t extra2;
  logic                       joy_strobe;
  logic [1:0]                 joy_clock;
  logic [1:0]                 joy_data;
  logic                       loading;
  logic                       loader_reset;
  logic                       nes_reset;
  logic                       sys_resetn;
  logic                       rv_valid;
  nes_glue_pkg::rv_req_t      rv_req;
  logic                       rv_ready;
  nes_glue_pkg::rv_data_t     rv_rdata;
  nes_glue_pkg::mem_req_t     mem_req;
  logic                       mem_toggle;
  logic                       mem_ack;
  nes_glue_pkg::mem_data_t    mem_dout;

  nes_glue_pkg::mem_data_t mem_model [nes_glue_pkg::mem_addr_t];
  nes_glue_pkg::mem_data_t old_half;
  logic [1:0]              last_ds;
  int                      toggle_count;
  int                      mem_delay;
  int                      err_count;
  int                      check_count;
  int                      test_count;

  nes_glue_top u_nes_glue_top (
    .clk            (clk),
    .resetn         (resetn),
    .i_reset_btn    (reset_btn),
    .i_pad1         (pad1),
    .i_pad2         (pad2),
    .i_extra1       (extra1),
    .i_extra2       (extra2),
    .i_joy_strobe   (joy_strobe),
    .i_joy_clock    (joy_clock),
    .o_joy_data     (joy_data),
    .i_loading      (loading),
    .o_loader_reset (loader_reset),
    .o_nes_reset    (nes_reset),
    .o_sys_resetn   (sys_resetn),
    .i_rv_valid     (rv_valid),
    .i_rv_req       (rv_req),
    .o_rv_ready     (rv_ready),
    .o_rv_rdata     (rv_rdata),
    .o_mem_req      (mem_req),
    .o_mem_toggle   (mem_toggle),
    .i_mem_ack      (mem_ack),
    .i_mem_dout     (mem_dout)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Untouched half-words hold a pattern of their address
  function automatic nes_glue_pkg::mem_data_t read_half(input nes_glue_pkg::mem_addr_t a);
    if (mem_model.exists(a))
      return mem_model[a];
    return a[15:0] ^ {a[19:16], 12'ha5c};
  endfunction

  function automatic nes_glue_pkg::rv_data_t read_word(input nes_glue_pkg::rv_addr_t a);
    return {read_half({a[20:2], 1'b1}), read_half({a[20:2], 1'b0})};
  endfunction

  function automatic nes_glue_pkg::rv_data_t merge_bytes(input nes_glue_pkg::rv_data_t old_w,
                                                         input nes_glue_pkg::rv_data_t new_w,
                                                         input nes_glue_pkg::rv_strb_t strb);
    nes_glue_pkg::rv_data_t res;
    res = old_w;
    for (int i = 0; i < 4; i++)
      if (strb[i])
        res[i*8 +: 8] = new_w[i*8 +: 8];
    return res;
  endfunction

  // Active low report bits placed in console button order
  function automatic nes_glue_pkg::nes_buttons_t map_pad(input nes_glue_pkg::pad_report_t r,
                                                         input nes_glue_pkg::nes_buttons_t x);
    nes_glue_pkg::nes_buttons_t b;
    b = {~r.byte0[5], ~r.byte0[7], ~r.byte0[6], ~r.byte0[4],
         ~r.byte0[3], ~r.byte0[0], ~r.byte1[6], ~r.byte1[5]};
    return b | x;
  endfunction

  // Memory responder serving one half-word access per toggle change
  initial begin
    mem_ack      = 1'b0;
    mem_dout     = '0;
    last_ds      = 2'b00;
    toggle_count = 0;
    forever begin
      @(negedge clk);
      if (mem_toggle != mem_ack) begin
        mem_delay = int'($urandom % 6);
        repeat (mem_delay) @(negedge clk);
        old_half = read_half(mem_req.addr);
        if (mem_req.we)
          mem_model[mem_req.addr] = {mem_req.ds[1] ? mem_req.din[15:8] : old_half[15:8],
                                     mem_req.ds[0] ? mem_req.din[7:0] : old_half[7:0]};
        else
          mem_dout = old_half;
        last_ds = mem_req.ds;
        toggle_count++;
        mem_ack = mem_toggle;
        @(negedge clk); // Hold read data through the capture cycle
      end
    end
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      $display("[FAIL] %s: expected 0x%h, got 0x%h", name, expected, actual);
      err_count++;
    end
  endtask

  task automatic wait_sys_resetn(input logic level, input int limit);
    int n;
    n = 0;
    while (sys_resetn !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (sys_resetn !== level) begin
      $display("Timeout: system reset did not go to %0b within %0d cycles", level, limit);
      err_count++;
    end
  endtask

  // One soft-core access with valid held until the ready pulse
  task automatic bus_access(input nes_glue_pkg::rv_addr_t addr,
                            input nes_glue_pkg::rv_data_t wdata,
                            input nes_glue_pkg::rv_strb_t wstrb,
                            output nes_glue_pkg::rv_data_t rdata);
    int n;
    n = 0;
    rdata = '0;
    @(negedge clk);
    rv_req.addr  = addr;
    rv_req.wdata = wdata;
    rv_req.wstrb = wstrb;
    rv_valid     = 1'b1;
    do begin
      @(negedge clk);
      n++;
    end while (!rv_ready && n < 100);
    if (rv_ready) begin
      rdata = rv_rdata;
    end else begin
      $display("Timeout: bus access to 0x%h got no ready within 100 cycles", addr);
      err_count++;
    end
    rv_valid = 1'b0;
  endtask

  task automatic reset_release();
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      check("o_sys_resetn", 32'd0, 32'(sys_resetn));
    end
    resetn = 1'b1;
    wait_sys_resetn(1'b1, int'(nes_glue_pkg::RESET_HOLD_CYCLES) + 5);
    reset_btn = 1'b1;
    wait_sys_resetn(1'b0, 4);
    reset_btn = 1'b0;
    wait_sys_resetn(1'b1, 4);
    pad1 = 16'hffbe; // Select and Down held
    wait_sys_resetn(1'b0, 4);
    pad1 = 16'hffff;
    wait_sys_resetn(1'b1, 4);
    test_count++;
    $display("reset release finished, %0d errors so far", err_count);
  endtask

  task automatic loading_control();
    int len;
    int pulses;
    len    = int'($urandom % 10) + 1;
    pulses = 0;
    check("o_nes_reset", 32'd1, 32'(nes_reset));
    for (int i = 0; i < len + 4; i++) begin
      @(negedge clk);
      loading = (i < len);
      #5;
      if (loader_reset)
        pulses++;
      check("o_nes_reset", (i <= len) ? 32'd1 : 32'd0, 32'(nes_reset));
    end
    check("o_loader_reset pulses", 32'd1, 32'(pulses));
    @(negedge clk);
    loading = 1'b1; // Next load raises the console reset again
    @(negedge clk);
    check("o_nes_reset", 32'd1, 32'(nes_reset));
    loading = 1'b0;
    test_count++;
    $display("loading control finished, %0d errors so far", err_count);
  endtask

  task automatic pad_readout();
    nes_glue_pkg::nes_buttons_t exp1;
    nes_glue_pkg::nes_buttons_t exp2;
    for (int t = 0; t < 4; t++) begin
      @(negedge clk);
      pad1   = 16'($urandom);
      pad2   = 16'($urandom);
      extra1 = 8'($urandom);
      extra2 = 8'($urandom);
      exp1   = map_pad(pad1, extra1);
      if (exp1[nes_glue_pkg::BTN_SELECT] && exp1[nes_glue_pkg::BTN_DOWN]) begin
        pad1.byte0[6] = 1'b1; // Release Down so the home combo stays off
        extra1[nes_glue_pkg::BTN_DOWN] = 1'b0;
        exp1 = map_pad(pad1, extra1);
      end
      exp2       = map_pad(pad2, extra2);
      joy_strobe = 1'b1;
      @(negedge clk);
      joy_strobe = 1'b0;
      for (int b = 0; b < 10; b++) begin
        @(negedge clk);
        check("o_joy_data[0]", 32'(exp1[0]), 32'(joy_data[0]));
        check("o_joy_data[1]", 32'(exp2[0]), 32'(joy_data[1]));
        joy_clock = 2'b11;
        @(negedge clk);
        joy_clock = 2'b00;
        exp1 = exp1 >> 1;
        exp2 = exp2 >> 1;
      end
    end
    test_count++;
    $display("pad readout finished, %0d errors so far", err_count);
  endtask

  task automatic full_write_read();
    nes_glue_pkg::rv_addr_t addr;
    nes_glue_pkg::rv_data_t wdata;
    nes_glue_pkg::rv_data_t rdata;
    addr  = 23'($urandom) & 23'h7ffffc;
    wdata = $urandom;
    bus_access(addr, wdata, 4'hf, rdata);
    check("memory lower half", 32'(wdata[15:0]), 32'(read_half({addr[20:2], 1'b0})));
    check("memory upper half", 32'(wdata[31:16]), 32'(read_half({addr[20:2], 1'b1})));
    bus_access(addr, '0, 4'h0, rdata);
    check("o_rv_rdata", wdata, rdata);
    test_count++;
    $display("full write and read finished, %0d errors so far", err_count);
  endtask

  task automatic partial_writes();
    nes_glue_pkg::rv_addr_t addr;
    nes_glue_pkg::rv_data_t base;
    nes_glue_pkg::rv_data_t wdata;
    nes_glue_pkg::rv_data_t rdata;
    nes_glue_pkg::rv_data_t expected;
    nes_glue_pkg::rv_strb_t strb;
    logic [1:0]             half;
    int                     start;
    for (int k = 0; k < 2; k++) begin
      addr  = 23'($urandom) & 23'h7ffffc;
      base  = $urandom;
      bus_access(addr, base, 4'hf, rdata);
      half  = 2'($urandom % 3 + 1);
      strb  = (k == 0) ? {half, 2'b00} : {2'b00, half}; // Upper first, then lower
      wdata = $urandom;
      start = toggle_count;
      bus_access(addr, wdata, strb, rdata);
      expected = merge_bytes(base, wdata, strb);
      check("memory toggles", 32'd1, 32'(toggle_count - start));
      check("o_mem_req.ds", 32'(half), 32'(last_ds));
      check("memory word", expected, read_word(addr));
      bus_access(addr, '0, 4'h0, rdata);
      check("o_rv_rdata", expected, rdata);
    end
    test_count++;
    $display("partial writes finished, %0d errors so far", err_count);
  endtask

  initial begin
    void'($urandom(32'he5b04bfc));
    err_count   = 0;
    check_count = 0;
    test_count  = 0;
    resetn      = 1'b0;
    reset_btn   = 1'b0;
    pad1        = 16'hffff; // Nothing pressed
    pad2        = 16'hffff;
    extra1      = '0;
    extra2      = '0;
    joy_strobe  = 1'b0;
    joy_clock   = 2'b00;
    loading     = 1'b0;
    rv_valid    = 1'b0;
    rv_req      = '0;

    reset_release();
    loading_control();
    pad_readout();
    full_write_read();
    partial_writes();

    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

//--- rtl/nes_glue_top.sv
// Console glue top level
// Reset sequencing, pad mapping, joypad ports and memory bridge
`timescale 1ns/1ns

module nes_glue_top (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic                       i_reset_btn,
  input  nes_glue_pkg::pad_report_t  i_pad1,
  input  nes_glue_pkg::pad_report_t  i_pad2,
  input  nes_glue_pkg::nes_buttons_t i_extra1,
  input  nes_glue_pkg::nes_buttons_t i_extra2,
  input  logic                       i_joy_strobe,
  input  logic [1:0]                 i_joy_clock,
  output logic [1:0]                 o_joy_data,
  input  logic                       i_loading,
  output logic                       o_loader_reset,
  output logic                       o_nes_reset,
  output logic                       o_sys_resetn,
  input  logic                       i_rv_valid,
  input  nes_glue_pkg::rv_req_t      i_rv_req,
  output logic                       o_rv_ready,
  output nes_glue_pkg::rv_data_t     o_rv_rdata,
  output nes_glue_pkg::mem_req_t     o_mem_req,
  output logic                       o_mem_toggle,
  input  logic                       i_mem_ack,
  input  nes_glue_pkg::mem_data_t    i_mem_dout
);

  nes_glue_pkg::nes_buttons_t p1_buttons;
  nes_glue_pkg::nes_buttons_t p2_buttons;

  reset_sequencer u_reset_sequencer (
    .clk            (clk),
    .resetn         (resetn),
    .i_reset_btn    (i_reset_btn),
    .i_p1_buttons   (p1_buttons), // Home combo
    .i_loading      (i_loading),
    .o_sys_resetn   (o_sys_resetn),
    .o_loader_reset (o_loader_reset),
    .o_nes_reset    (o_nes_reset)
  );

  pad_mapper u_pad_mapper1 (
    .i_report  (i_pad1),
    .i_extra   (i_extra1),
    .o_buttons (p1_buttons)
  );

  pad_mapper u_pad_mapper2 (
    .i_report  (i_pad2),
    .i_extra   (i_extra2),
    .o_buttons (p2_buttons)
  );

  joypad_shifter u_joypad_shifter1 (
    .clk          (clk),
    .resetn       (o_sys_resetn),
    .i_buttons    (p1_buttons),
    .i_strobe     (i_joy_strobe),
    .i_port_clock (i_joy_clock[0]),
    .o_data       (o_joy_data[0])
  );

  joypad_shifter u_joypad_shifter2 (
    .clk          (clk),
    .resetn       (o_sys_resetn),
    .i_buttons    (p2_buttons),
    .i_strobe     (i_joy_strobe),
    .i_port_clock (i_joy_clock[1]),
    .o_data       (o_joy_data[1])
  );

  rv_mem_bridge u_rv_mem_bridge (
    .clk          (clk),
    .resetn       (o_sys_resetn),
    .i_rv_valid   (i_rv_valid),
    .i_rv_req     (i_rv_req),
    .o_rv_ready   (o_rv_ready),
    .o_rv_rdata   (o_rv_rdata),
    .o_mem_req    (o_mem_req),
    .o_mem_toggle (o_mem_toggle),
    .i_mem_ack    (i_mem_ack),
    .i_mem_dout   (i_mem_dout)
  );

endmodule

//--- rtl/rv_mem_bridge.sv
// Soft-core 32-bit bus to 16-bit memory port bridge
// Toggle request/acknowledge, two half-word accesses per word
// Halves with zero write strobes are skipped
`timescale 1ns/1ns

module rv_mem_bridge (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   i_rv_valid,
  input  nes_glue_pkg::rv_req_t  i_rv_req,
  output logic                   o_rv_ready,
  output nes_glue_pkg::rv_data_t o_rv_rdata,
  output nes_glue_pkg::mem_req_t o_mem_req,
  output logic                   o_mem_toggle,
  input  logic                   i_mem_ack,
  input  nes_glue_pkg::mem_data_t i_mem_dout
);

  nes_glue_pkg::bridge_state_t state;
  nes_glue_pkg::mem_data_t     dout0_q;  // Lower half of a read
  logic                        valid_q;
  logic                        new_req_q; // Request seen while busy
  logic                        new_req;
  logic                        word_q;    // Half select
  logic [1:0]                  ds_q;
  logic                        write;
  logic                        acked;

  assign write   = i_rv_req.wstrb != 4'b0000;
  assign new_req = i_rv_valid & ~valid_q;
  assign acked   = o_mem_toggle == i_mem_ack;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state        <= nes_glue_pkg::IDLE_REQ0;
      o_rv_ready   <= 1'b0;
      o_mem_toggle <= 1'b0;
      valid_q      <= 1'b0;
      new_req_q    <= 1'b0;
    end else begin
      if (new_req)
        new_req_q <= 1'b1;
      o_rv_ready <= 1'b0;
      valid_q    <= i_rv_valid;

      case (state)
        nes_glue_pkg::IDLE_REQ0: begin
          if (new_req_q || new_req) begin
            new_req_q    <= 1'b0;
            o_mem_toggle <= ~o_mem_toggle;
            if (write && i_rv_req.wstrb[1:0] == 2'b00) begin
              word_q <= 1'b1; // Upper half only
              ds_q   <= i_rv_req.wstrb[3:2];
              state  <= nes_glue_pkg::WAIT1;
            end else begin
              word_q <= 1'b0;
              ds_q   <= write ? i_rv_req.wstrb[1:0] : 2'b11;
              state  <= nes_glue_pkg::WAIT0_REQ1;
            end
          end
        end

        nes_glue_pkg::WAIT0_REQ1: begin
          if (acked) begin
            word_q <= 1'b1;
            if (!write) begin
              o_mem_toggle <= ~o_mem_toggle;
              ds_q         <= 2'b11;
              state        <= nes_glue_pkg::DATA0;
            end else if (i_rv_req.wstrb[3:2] == 2'b00) begin
              o_rv_ready <= 1'b1; // Lower half was all
              state      <= nes_glue_pkg::IDLE_REQ0;
            end else begin
              o_mem_toggle <= ~o_mem_toggle;
              ds_q         <= i_rv_req.wstrb[3:2];
              state        <= nes_glue_pkg::WAIT1;
            end
          end
        end

        nes_glue_pkg::DATA0: begin
          state <= nes_glue_pkg::WAIT1;
        end

        nes_glue_pkg::WAIT1: begin
          if (acked) begin
            if (write) begin
              o_rv_ready <= 1'b1;
              state      <= nes_glue_pkg::IDLE_REQ0;
            end else begin
              state <= nes_glue_pkg::DATA1;
            end
          end
        end

        nes_glue_pkg::DATA1: begin
          o_rv_ready <= 1'b1;
          state      <= nes_glue_pkg::IDLE_REQ0;
        end

        default: state <= nes_glue_pkg::IDLE_REQ0;
      endcase
    end
  end

  // Lower read half is held one cycle after its ack
  always_ff @(posedge clk) begin
    if (state == nes_glue_pkg::DATA0)
      dout0_q <= i_mem_dout;
  end

  assign o_rv_rdata = {i_mem_dout, dout0_q};

  // Request fields follow the held soft-core request
  assign o_mem_req.addr = {i_rv_req.addr[20:2], word_q};
  assign o_mem_req.din  = word_q ? i_rv_req.wdata[31:16] : i_rv_req.wdata[15:0];
  assign o_mem_req.ds   = ds_q;
  assign o_mem_req.we   = write;

endmodule

//--- rtl/joypad_shifter.sv
// One console joypad port
// Parallel load on strobe, right shift on falling port clock
`timescale 1ns/1ns

module joypad_shifter (
  input  logic                      clk,
  input  logic                      resetn,
  input  nes_glue_pkg::nes_buttons_t i_buttons,
  input  logic                      i_strobe,
  input  logic                      i_port_clock,
  output logic                      o_data
);

  nes_glue_pkg::nes_buttons_t shift_q;
  logic                       port_clock_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      shift_q      <= '0;
      port_clock_q <= 1'b0;
    end else begin
      if (i_strobe)
        shift_q <= i_buttons;
      // Later assignment wins, so a shift overrides a reload
      if (port_clock_q && !i_port_clock)
        shift_q <= {1'b0, shift_q[7:1]};
      port_clock_q <= i_port_clock;
    end
  end

  assign o_data = shift_q[0]; // A button comes out first

endmodule

//--- rtl/pad_mapper.sv
// Gamepad report to console button byte mapping
`timescale 1ns/1ns

module pad_mapper (
  input  nes_glue_pkg::pad_report_t  i_report,
  input  nes_glue_pkg::nes_buttons_t i_extra,
  output nes_glue_pkg::nes_buttons_t o_buttons
);

  nes_glue_pkg::nes_buttons_t mapped;

  // Report bits are active low
  always_comb begin
    mapped                          = '0;
    mapped[nes_glue_pkg::BTN_RIGHT]  = ~i_report.byte0[5];
    mapped[nes_glue_pkg::BTN_LEFT]   = ~i_report.byte0[7];
    mapped[nes_glue_pkg::BTN_DOWN]   = ~i_report.byte0[6];
    mapped[nes_glue_pkg::BTN_UP]     = ~i_report.byte0[4];
    mapped[nes_glue_pkg::BTN_START]  = ~i_report.byte0[3];
    mapped[nes_glue_pkg::BTN_SELECT] = ~i_report.byte0[0];
    mapped[nes_glue_pkg::BTN_B]      = ~i_report.byte1[6]; // Square
    mapped[nes_glue_pkg::BTN_A]      = ~i_report.byte1[5]; // Circle
  end

  // Second source is already in console order
  assign o_buttons = mapped | i_extra;

endmodule

//--- rtl/reset_sequencer.sv
// Power-on reset countdown with button and home-combo reset
// Loader reset pulse and console reset level from the loading flag
`timescale 1ns/1ns

module reset_sequencer (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      i_reset_btn,
  input  nes_glue_pkg::nes_buttons_t i_p1_buttons,
  input  logic                      i_loading,
  output logic                      o_sys_resetn,
  output logic                      o_loader_reset,
  output logic                      o_nes_reset
);

  logic [7:0] hold_cnt;
  logic       home_combo;
  logic       loading_q;

  // Select + Down acts as the home button
  assign home_combo = i_p1_buttons[nes_glue_pkg::BTN_SELECT] &
                      i_p1_buttons[nes_glue_pkg::BTN_DOWN];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      hold_cnt     <= nes_glue_pkg::RESET_HOLD_CYCLES;
      o_sys_resetn <= 1'b0;
    end else begin
      if (hold_cnt != 8'd0)
        hold_cnt <= hold_cnt - 8'd1;
      else
        o_sys_resetn <= ~i_reset_btn & ~home_combo; // Follows sources after countdown
    end
  end

  // First cycle of a loading period
  assign o_loader_reset = i_loading & ~loading_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      loading_q   <= 1'b0;
      o_nes_reset <= 1'b1; // Console held until a ROM is loaded
    end else begin
      loading_q <= i_loading;
      if (~i_loading & loading_q)
        o_nes_reset <= 1'b0;
      else if (i_loading & ~loading_q)
        o_nes_reset <= 1'b1;
    end
  end

endmodule

//--- rtl/nes_glue_pkg.sv
// Shared widths, types and structs for the console glue core
// Button byte layout, pad report, soft-core and memory requests
// Bridge state encoding
package nes_glue_pkg;

  // Forced reset length after resetn release
  localparam logic [7:0] RESET_HOLD_CYCLES = 8'd255;

  // Bit positions in the console button byte
  localparam int BTN_A      = 0;
  localparam int BTN_B      = 1;
  localparam int BTN_SELECT = 2;
  localparam int BTN_START  = 3;
  localparam int BTN_UP     = 4;
  localparam int BTN_DOWN   = 5;
  localparam int BTN_LEFT   = 6;
  localparam int BTN_RIGHT  = 7;

  // Right Left Down Up Start Select B A from the MSB down
  typedef logic [7:0] nes_buttons_t;

  // Raw gamepad report with active low bits
  typedef struct packed {
    logic [7:0] byte1;
    logic [7:0] byte0;
  } pad_report_t;

  typedef logic [22:0] rv_addr_t;
  typedef logic [31:0] rv_data_t;
  typedef logic [3:0]  rv_strb_t;

  typedef struct packed {
    rv_addr_t addr;
    rv_data_t wdata;
    rv_strb_t wstrb; // All zero means read
  } rv_req_t;

  typedef logic [19:0] mem_addr_t; // Word address plus half select
  typedef logic [15:0] mem_data_t;

  typedef struct packed {
    mem_addr_t  addr;
    mem_data_t  din;
    logic [1:0] ds;
    logic       we;
  } mem_req_t;

  typedef enum logic [2:0] {
    IDLE_REQ0,
    WAIT0_REQ1,
    DATA0,
    WAIT1,
    DATA1
  } bridge_state_t;

endpackage
